// ==== filelist.f ====
hdl/issue_pkg.sv
hdl/dispatch_if.sv
hdl/regfile.sv
hdl/dispatch_unit.sv
hdl/fu_status_table.sv
hdl/issue_select.sv
hdl/issue_top.sv
verification/issue_checker.sv
verification/issue_tb.sv

// ==== hdl/dispatch_if.sv ====
// Dispatch to status table link
// Carries the allocated row one way and the per-class credit return the other
`timescale 1ns/100ps

interface dispatch_if;

    logic                              alloc_en;
    issue_pkg::fust_row_t              alloc_row;
    issue_pkg::tag_t                   alloc_tag;  // Target row
    logic [issue_pkg::NUM_CLASSES-1:0] credit_ret; // One-hot per class
    issue_pkg::tag_t                   credit_tag; // Row just freed

    modport DISP (
        output alloc_en,
        output alloc_row,
        output alloc_tag,
        input  credit_ret,
        input  credit_tag
    );

    modport TBL (
        input  alloc_en,
        input  alloc_row,
        input  alloc_tag,
        output credit_ret,
        output credit_tag
    );

endinterface

// ==== hdl/dispatch_unit.sv ====
// Dispatch unit
// Tracks credits and pending register writers, builds rows for the status table
`timescale 1ns/100ps

module dispatch_unit #(
    parameter int SLOTS_PER_CLASS = 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                disp_valid,
    input  issue_pkg::op_e      disp_op,
    input  issue_pkg::reg_sel_t disp_rd,
    input  issue_pkg::reg_sel_t disp_rs1,
    input  issue_pkg::reg_sel_t disp_rs2,
    input  logic                wb_valid,
    input  issue_pkg::tag_t     wb_tag,
    input  issue_pkg::data_t    wb_data,
    input  issue_pkg::data_t    rdat1,
    input  issue_pkg::data_t    rdat2,
    output logic                disp_ready,
    output issue_pkg::reg_sel_t rsel1,
    output issue_pkg::reg_sel_t rsel2,
    output logic                wen,
    output issue_pkg::reg_sel_t wsel,
    output issue_pkg::data_t    wdata,
    dispatch_if.DISP            dif
);

    localparam int NROWS = issue_pkg::NUM_CLASSES * SLOTS_PER_CLASS;
    localparam int CNT_W = $clog2(SLOTS_PER_CLASS + 1);

    issue_pkg::fu_class_e disp_class;
    issue_pkg::tag_t      free_row;
    issue_pkg::fust_row_t row;
    issue_pkg::age_t      age_cnt;
    logic [CNT_W-1:0]     credit_cnt [issue_pkg::NUM_CLASSES];
    logic [NROWS-1:0]     free_mask;
    logic [31:0]          stat_vld;     // Register has a pending writer
    issue_pkg::tag_t      stat_tag [32];
    issue_pkg::reg_sel_t  tag_rd [NROWS];
    logic                 alloc_en;

    function automatic issue_pkg::fu_class_e op_class(input issue_pkg::op_e op);
        case (op)
            issue_pkg::OP_MUL: return issue_pkg::FU_MUL;
            issue_pkg::OP_LD:  return issue_pkg::FU_LDST;
            default:           return issue_pkg::FU_ALU;
        endcase
    endfunction

    assign disp_class = op_class(disp_op);
    assign disp_ready = credit_cnt[disp_class] != '0;
    assign alloc_en   = disp_valid && disp_ready;

    // Lowest free row inside this class's block
    always_comb begin
        free_row = '0;
        for (int i = NROWS - 1; i >= 0; i--) begin
            if (free_mask[i] && (i / SLOTS_PER_CLASS) == int'(disp_class)) begin
                free_row = issue_pkg::tag_t'(i);
            end
        end
    end

    assign rsel1 = disp_rs1;
    assign rsel2 = disp_rs2;

    // Writeback only lands if no newer writer took the register
    assign wsel  = tag_rd[wb_tag];
    assign wdata = wb_data;
    assign wen   = wb_valid && stat_vld[wsel] && stat_tag[wsel] == wb_tag;

    always_comb begin
        row     = '0;
        row.op  = disp_op;
        row.fu  = disp_class;
        row.rd  = disp_rd;
        row.age = age_cnt;
        if (stat_vld[disp_rs1] && !(wb_valid && wb_tag == stat_tag[disp_rs1])) begin
            row.t1_vld = 1'b1;
            row.t1     = stat_tag[disp_rs1];
        end else if (stat_vld[disp_rs1]) begin
            row.val1 = wb_data; // Producer writes back this cycle
        end else begin
            row.val1 = rdat1;
        end
        if (stat_vld[disp_rs2] && !(wb_valid && wb_tag == stat_tag[disp_rs2])) begin
            row.t2_vld = 1'b1;
            row.t2     = stat_tag[disp_rs2];
        end else if (stat_vld[disp_rs2]) begin
            row.val2 = wb_data;
        end else begin
            row.val2 = rdat2;
        end
    end

    assign dif.alloc_en  = alloc_en;
    assign dif.alloc_tag = free_row;
    assign dif.alloc_row = row;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int c = 0; c < issue_pkg::NUM_CLASSES; c++) begin
                credit_cnt[c] <= CNT_W'(SLOTS_PER_CLASS);
            end
            free_mask <= '1;
            stat_vld  <= '0;
            age_cnt   <= '0;
        end else begin
            for (int c = 0; c < issue_pkg::NUM_CLASSES; c++) begin
                if (alloc_en && int'(disp_class) == c && !dif.credit_ret[c]) begin
                    credit_cnt[c] <= credit_cnt[c] - 1'b1;
                end else if (!(alloc_en && int'(disp_class) == c) && dif.credit_ret[c]) begin
                    credit_cnt[c] <= credit_cnt[c] + 1'b1;
                end
            end
            if (dif.credit_ret != '0) free_mask[dif.credit_tag] <= 1'b1;
            if (wen) stat_vld[wsel] <= 1'b0;
            if (alloc_en) begin
                free_mask[free_row] <= 1'b0;
                age_cnt             <= age_cnt + 1'b1;
                if (disp_rd != '0) stat_vld[disp_rd] <= 1'b1; // New writer wins
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (alloc_en) begin
            stat_tag[disp_rd] <= free_row;
            tag_rd[free_row]  <= disp_rd;
        end
    end

endmodule

// ==== hdl/fu_status_table.sv ====
// Functional-unit status table
// Holds waiting rows, captures writeback operands, frees rows and returns credits
`timescale 1ns/100ps

module fu_status_table #(
    parameter int SLOTS_PER_CLASS = 2
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 wb_valid,
    input  issue_pkg::tag_t      wb_tag,
    input  issue_pkg::data_t     wb_data,
    input  logic [issue_pkg::NUM_CLASSES*SLOTS_PER_CLASS-1:0] issue_grant,
    input  logic                 issue_stall,
    output logic [issue_pkg::NUM_CLASSES*SLOTS_PER_CLASS-1:0] row_rdy,
    output issue_pkg::fust_row_t [issue_pkg::NUM_CLASSES*SLOTS_PER_CLASS-1:0] rows,
    dispatch_if.TBL              dif
);

    localparam int NROWS = issue_pkg::NUM_CLASSES * SLOTS_PER_CLASS;

    issue_pkg::row_state_e state [NROWS];
    issue_pkg::fust_row_t  rows_q [NROWS];
    logic                  wb_frees;

    // A writeback for an issued row retires it
    assign wb_frees = wb_valid && state[wb_tag] == issue_pkg::ROW_EX;

    always_comb begin
        for (int i = 0; i < NROWS; i++) begin
            row_rdy[i] = state[i] == issue_pkg::ROW_RDY;
            rows[i]    = rows_q[i];
        end
    end

    // Row FSM
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NROWS; i++) begin
                state[i] <= issue_pkg::ROW_EMPTY;
            end
        end else begin
            for (int i = 0; i < NROWS; i++) begin
                case (state[i])
                    issue_pkg::ROW_EMPTY: begin
                        if (dif.alloc_en && dif.alloc_tag == issue_pkg::tag_t'(i)) begin
                            state[i] <= issue_pkg::ROW_WAIT;
                        end
                    end
                    issue_pkg::ROW_WAIT: begin
                        // Tags cleared at an earlier edge, promote now
                        if (!issue_stall && !rows_q[i].t1_vld && !rows_q[i].t2_vld) begin
                            state[i] <= issue_pkg::ROW_RDY;
                        end
                    end
                    issue_pkg::ROW_RDY: begin
                        if (issue_grant[i] && !issue_stall) state[i] <= issue_pkg::ROW_EX;
                    end
                    default: begin
                        if (wb_valid && wb_tag == issue_pkg::tag_t'(i)) begin
                            state[i] <= issue_pkg::ROW_EMPTY;
                        end
                    end
                endcase
            end
        end
    end

    // Row payload and operand capture from the writeback broadcast
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NROWS; i++) begin
            if (dif.alloc_en && dif.alloc_tag == issue_pkg::tag_t'(i)) begin
                rows_q[i] <= dif.alloc_row;
            end else if (wb_valid && state[i] == issue_pkg::ROW_WAIT) begin
                if (rows_q[i].t1_vld && rows_q[i].t1 == wb_tag) begin
                    rows_q[i].val1   <= wb_data;
                    rows_q[i].t1_vld <= 1'b0;
                end
                if (rows_q[i].t2_vld && rows_q[i].t2 == wb_tag) begin
                    rows_q[i].val2   <= wb_data;
                    rows_q[i].t2_vld <= 1'b0;
                end
            end
        end
    end

    // Credit goes back one cycle after the row empties
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dif.credit_ret <= '0;
            dif.credit_tag <= '0;
        end else begin
            dif.credit_ret <= '0;
            if (wb_frees) begin
                dif.credit_ret[rows_q[wb_tag].fu] <= 1'b1;
                dif.credit_tag                    <= wb_tag;
            end
        end
    end

endmodule

// ==== hdl/issue_pkg.sv ====
// Issue stage shared definitions
// Operand, tag, opcode and row types plus default sizing constants
package issue_pkg;

    typedef logic [31:0] data_t;    // Operand or result word
    typedef logic [4:0]  reg_sel_t; // Architectural register number
    typedef logic [2:0]  tag_t;     // Status table row index

    // Functional-unit classes, each owning one block of rows
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_LDST
    } fu_class_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL,
        OP_LD
    } op_e;

    typedef enum logic [1:0] {
        ROW_EMPTY,
        ROW_WAIT,  // Waiting on one or both source tags
        ROW_RDY,
        ROW_EX     // Issued, waiting for writeback
    } row_state_e;

    parameter int NUM_CLASSES         = 3;
    parameter int SLOTS_PER_CLASS_DEF = 2;
    parameter int AGE_W               = 4; // Wraps, compared modulo 2**AGE_W

    typedef logic [AGE_W-1:0] age_t;

    typedef struct packed {
        op_e       op;
        fu_class_e fu;
        reg_sel_t  rd;
        data_t     val1;
        data_t     val2;
        logic      t1_vld;
        tag_t      t1;
        logic      t2_vld;
        tag_t      t2;
        age_t      age;
    } fust_row_t;

endpackage

// ==== hdl/issue_select.sv ====
// Issue selector
// Picks the oldest ready row and registers it onto the issue port
`timescale 1ns/100ps

module issue_select #(
    parameter int SLOTS_PER_CLASS = 2
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [issue_pkg::NUM_CLASSES*SLOTS_PER_CLASS-1:0] row_rdy,
    input  issue_pkg::fust_row_t [issue_pkg::NUM_CLASSES*SLOTS_PER_CLASS-1:0] rows,
    input  logic                 issue_stall,
    output logic [issue_pkg::NUM_CLASSES*SLOTS_PER_CLASS-1:0] issue_grant,
    output logic                 issue_valid,
    output issue_pkg::op_e       issue_op,
    output issue_pkg::tag_t      issue_tag,
    output issue_pkg::data_t     issue_rdat1,
    output issue_pkg::data_t     issue_rdat2
);

    localparam int NROWS = issue_pkg::NUM_CLASSES * SLOTS_PER_CLASS;

    logic            found;
    issue_pkg::tag_t pick;
    issue_pkg::age_t best_age;
    issue_pkg::age_t age_diff;

    // Oldest ready row; ages wrap, so older means a negative modular difference
    always_comb begin
        found    = 1'b0;
        pick     = '0;
        best_age = '0;
        age_diff = '0;
        for (int i = 0; i < NROWS; i++) begin
            age_diff = rows[i].age - best_age;
            // Strict compare keeps the lower row on a tie
            if (row_rdy[i] && (!found || age_diff[issue_pkg::AGE_W-1])) begin
                found    = 1'b1;
                pick     = issue_pkg::tag_t'(i);
                best_age = rows[i].age;
            end
        end
    end

    always_comb begin
        issue_grant = '0;
        if (found && !issue_stall) issue_grant[pick] = 1'b1;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else if (!issue_stall) begin
            issue_valid <= found; // Held through a stall
        end
    end

    always_ff @(posedge CLK) begin
        if (!issue_stall && found) begin
            issue_op    <= rows[pick].op;
            issue_tag   <= pick;
            issue_rdat1 <= rows[pick].val1;
            issue_rdat2 <= rows[pick].val2;
        end
    end

endmodule

// ==== hdl/issue_top.sv ====
// Issue stage top level
// Dispatch, register file, status table and oldest-first selector
`timescale 1ns/100ps

module issue_top #(
    parameter int SLOTS_PER_CLASS = issue_pkg::SLOTS_PER_CLASS_DEF
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                disp_valid,
    input  issue_pkg::op_e      disp_op,
    input  issue_pkg::reg_sel_t disp_rd,
    input  issue_pkg::reg_sel_t disp_rs1,
    input  issue_pkg::reg_sel_t disp_rs2,
    output logic                disp_ready,
    input  logic                issue_stall,
    output logic                issue_valid,
    output issue_pkg::op_e      issue_op,
    output issue_pkg::tag_t     issue_tag,
    output issue_pkg::data_t    issue_rdat1,
    output issue_pkg::data_t    issue_rdat2,
    input  logic                wb_valid,
    input  issue_pkg::tag_t     wb_tag,
    input  issue_pkg::data_t    wb_data
);

    localparam int NROWS = issue_pkg::NUM_CLASSES * SLOTS_PER_CLASS;

    issue_pkg::reg_sel_t  rsel1;
    issue_pkg::reg_sel_t  rsel2;
    issue_pkg::reg_sel_t  wsel;
    issue_pkg::data_t     rdat1;
    issue_pkg::data_t     rdat2;
    issue_pkg::data_t     wdata;
    logic                 wen;
    logic [NROWS-1:0]     row_rdy;
    logic [NROWS-1:0]     issue_grant;
    issue_pkg::fust_row_t [NROWS-1:0] rows;

    dispatch_if dif ();

    dispatch_unit #(.SLOTS_PER_CLASS(SLOTS_PER_CLASS)) dispatch_unit_i (
        .CLK(CLK), .nRST(nRST),
        .disp_valid(disp_valid), .disp_op(disp_op), .disp_rd(disp_rd),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data),
        .rdat1(rdat1), .rdat2(rdat2), .disp_ready(disp_ready),
        .rsel1(rsel1), .rsel2(rsel2),
        .wen(wen), .wsel(wsel), .wdata(wdata),
        .dif(dif.DISP)
    );

    regfile regfile_i (
        .CLK(CLK), .nRST(nRST),
        .wen(wen), .wsel(wsel), .wdata(wdata),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2)
    );

    fu_status_table #(.SLOTS_PER_CLASS(SLOTS_PER_CLASS)) fu_status_table_i (
        .CLK(CLK), .nRST(nRST),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data),
        .issue_grant(issue_grant), .issue_stall(issue_stall),
        .row_rdy(row_rdy), .rows(rows),
        .dif(dif.TBL)
    );

    issue_select #(.SLOTS_PER_CLASS(SLOTS_PER_CLASS)) issue_select_i (
        .CLK(CLK), .nRST(nRST),
        .row_rdy(row_rdy), .rows(rows), .issue_stall(issue_stall),
        .issue_grant(issue_grant), .issue_valid(issue_valid),
        .issue_op(issue_op), .issue_tag(issue_tag),
        .issue_rdat1(issue_rdat1), .issue_rdat2(issue_rdat2)
    );

endmodule

// ==== hdl/regfile.sv ====
// Register file, 32 x 32 bits
// Two combinational read ports, one write port, register 0 reads zero
`timescale 1ns/100ps

module regfile (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                wen,
    input  issue_pkg::reg_sel_t wsel,
    input  issue_pkg::data_t    wdata,
    input  issue_pkg::reg_sel_t rsel1,
    input  issue_pkg::reg_sel_t rsel2,
    output issue_pkg::data_t    rdat1,
    output issue_pkg::data_t    rdat2
);

    issue_pkg::data_t regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the issue stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module issue_tb -o issue_sim \
    && ./obj_dir/issue_sim > sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

// ==== verification/issue_checker.sv ====
// Issue stage checker
// Replays dispatched instructions in order and compares every issue against it
`timescale 1ns/100ps

module issue_checker #(
    parameter int SLOTS_PER_CLASS = 2
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                disp_valid,
    input  issue_pkg::op_e      disp_op,
    input  issue_pkg::reg_sel_t disp_rd,
    input  issue_pkg::reg_sel_t disp_rs1,
    input  issue_pkg::reg_sel_t disp_rs2,
    input  logic                disp_ready,
    input  logic                issue_stall,
    input  logic                issue_valid,
    input  issue_pkg::op_e      issue_op,
    input  issue_pkg::tag_t     issue_tag,
    input  issue_pkg::data_t    issue_rdat1,
    input  issue_pkg::data_t    issue_rdat2,
    input  logic                wb_valid,
    input  issue_pkg::tag_t     wb_tag,
    input  logic                order_chk,  // Issues must follow dispatch order
    output int                  errors,
    output int                  n_disp,
    output int                  n_issue
);

    localparam int NROWS = issue_pkg::NUM_CLASSES * SLOTS_PER_CLASS;

    issue_pkg::data_t ref_regs [32];   // In-order architectural state
    issue_pkg::op_e   exp_op [NROWS];
    issue_pkg::data_t exp_a [NROWS];
    issue_pkg::data_t exp_b [NROWS];
    logic             live [NROWS];    // Row holds a dispatched instruction
    logic             issued [NROWS];
    int               freed_at [NROWS];
    int               seq [NROWS];
    int               cyc;
    int               last_seq;
    int               row;
    logic             prev_stall;
    logic             prev_valid;
    issue_pkg::op_e   prev_op;
    issue_pkg::tag_t  prev_tag;
    issue_pkg::data_t prev_a;
    issue_pkg::data_t prev_b;

    function automatic issue_pkg::data_t exec_ref(input issue_pkg::op_e op,
                                                  input issue_pkg::data_t a,
                                                  input issue_pkg::data_t b);
        case (op)
            issue_pkg::OP_ADD: return a + b;
            issue_pkg::OP_SUB: return a - b;
            issue_pkg::OP_XOR: return a ^ b;
            issue_pkg::OP_MUL: return a * b;
            default:           return (a + b) ^ 32'hA5A5_0000; // Load from address a + b
        endcase
    endfunction

    // Lowest row of the class block whose credit has had time to come back
    function automatic int pick_row(input issue_pkg::op_e op);
        int cls;
        cls = (op == issue_pkg::OP_MUL) ? 1 : (op == issue_pkg::OP_LD) ? 2 : 0;
        for (int i = cls * SLOTS_PER_CLASS; i < (cls + 1) * SLOTS_PER_CLASS; i++) begin
            if (!live[i] && cyc >= freed_at[i] + 2) return i;
        end
        return -1;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) ref_regs[i] = '0;
            for (int i = 0; i < NROWS; i++) begin
                live[i]     = 1'b0;
                issued[i]   = 1'b0;
                freed_at[i] = -10;
            end
            errors     = 0;
            n_disp     = 0;
            n_issue    = 0;
            cyc        = 0;
            last_seq   = -1;
            prev_stall = 1'b0;
        end else begin
            // Outputs sampled here must equal those of the previous edge if it was stalled
            if (prev_stall) begin
                if (issue_valid !== prev_valid) mismatch("issue_valid", prev_valid, issue_valid);
                if (prev_valid && issue_tag !== prev_tag) mismatch("issue_tag", prev_tag, issue_tag);
                if (prev_valid && issue_op !== prev_op) mismatch("issue_op", prev_op, issue_op);
                if (prev_valid && issue_rdat1 !== prev_a) begin
                    mismatch("issue_rdat1", prev_a, issue_rdat1);
                end
                if (prev_valid && issue_rdat2 !== prev_b) begin
                    mismatch("issue_rdat2", prev_b, issue_rdat2);
                end
            end
            if (!order_chk) last_seq = -1;
            if (issue_valid && !issue_stall) begin
                if (!live[issue_tag] || issued[issue_tag]) begin
                    $display("ERROR t=%0t row %0d issued with no waiting instruction",
                             $time, issue_tag);
                    errors++;
                end else begin
                    if (issue_op !== exp_op[issue_tag]) begin
                        mismatch("issue_op", exp_op[issue_tag], issue_op);
                    end
                    if (issue_rdat1 !== exp_a[issue_tag]) begin
                        mismatch("issue_rdat1", exp_a[issue_tag], issue_rdat1);
                    end
                    if (issue_rdat2 !== exp_b[issue_tag]) begin
                        mismatch("issue_rdat2", exp_b[issue_tag], issue_rdat2);
                    end
                    if (order_chk && seq[issue_tag] < last_seq) begin
                        $display("ERROR t=%0t instruction %0d issued after a younger one",
                                 $time, seq[issue_tag]);
                        errors++;
                    end
                    last_seq = seq[issue_tag];
                    issued[issue_tag] = 1'b1;
                end
                n_issue++;
            end
            if (wb_valid) begin
                live[wb_tag]     = 1'b0;
                freed_at[wb_tag] = cyc;
            end
            if (disp_valid && disp_ready) begin
                row = pick_row(disp_op);
                if (row < 0) begin
                    $display("ERROR t=%0t instruction accepted with no free row in its class",
                             $time);
                    errors++;
                end else begin
                    live[row]   = 1'b1;
                    issued[row] = 1'b0;
                    seq[row]    = n_disp;
                    exp_op[row] = disp_op;
                    exp_a[row]  = ref_regs[disp_rs1];
                    exp_b[row]  = ref_regs[disp_rs2];
                end
                if (disp_rd != '0) ref_regs[disp_rd] = exec_ref(disp_op, ref_regs[disp_rs1],
                                                                ref_regs[disp_rs2]);
                n_disp++;
            end
            prev_stall = issue_stall;
            prev_valid = issue_valid;
            prev_op    = issue_op;
            prev_tag   = issue_tag;
            prev_a     = issue_rdat1;
            prev_b     = issue_rdat2;
            cyc++;
        end
    end

endmodule

// ==== verification/issue_tb.sv ====
// Issue stage testbench
// Clock, reset, dispatch stimulus, functional-unit model with writeback, timeout
`timescale 1ns/100ps

module issue_tb;

    localparam int N_RAND  = 40;
    localparam int N_HOLD  = 8;
    localparam int N_TOTAL = N_RAND + N_HOLD + 4 + 5;
    localparam int LIMIT   = N_TOTAL * 40 + 200;

    logic CLK, nRST, disp_valid, disp_ready, issue_stall, issue_valid, wb_valid;
    issue_pkg::op_e      disp_op, issue_op;
    issue_pkg::reg_sel_t disp_rd, disp_rs1, disp_rs2;
    issue_pkg::tag_t     issue_tag, wb_tag;
    issue_pkg::data_t    issue_rdat1, issue_rdat2, wb_data;
    logic order_chk, stall_rand, stall_force, fu_hold;
    int   chk_errors, n_disp, n_issue, tb_errs, tests_run, tests_failed, err_mark, t0;
    int   cyc = 0;                  // Rising edges since time zero
    issue_pkg::tag_t  wbq_tag [$];  // Results in flight in the FU model
    issue_pkg::data_t wbq_data [$];
    int               wbq_due [$];

    issue_top issue_top_i (.*);

    issue_checker chk_i (.*, .errors(chk_errors));

    function automatic issue_pkg::data_t fu_result(input issue_pkg::op_e op,
                                                   input issue_pkg::data_t a,
                                                   input issue_pkg::data_t b);
        case (op)
            issue_pkg::OP_ADD: return a + b;
            issue_pkg::OP_SUB: return a - b;
            issue_pkg::OP_XOR: return a ^ b;
            issue_pkg::OP_MUL: return a * b;
            default:           return (a + b) ^ 32'hA5A5_0000;
        endcase
    endfunction

    task automatic send(input issue_pkg::op_e op, input int rd, input int rs1, input int rs2);
        @(negedge CLK);
        disp_valid = 1'b1;
        disp_op    = op;
        disp_rd    = issue_pkg::reg_sel_t'(rd);
        disp_rs1   = issue_pkg::reg_sel_t'(rs1);
        disp_rs2   = issue_pkg::reg_sel_t'(rs2);
        #1;
        while (!disp_ready) begin
            @(negedge CLK);
            #1;
        end
        @(posedge CLK); // Accepted at this edge
    endtask

    task automatic drain();
        @(negedge CLK);
        disp_valid = 1'b0;
        while (n_issue != n_disp || wbq_tag.size() != 0) @(negedge CLK);
        repeat (3) @(negedge CLK); // Let the last credits return
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (chk_errors + tb_errs != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     chk_errors + tb_errs - err_mark);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        err_mark = chk_errors + tb_errs;
    endtask

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Timeout and cycle count
    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d issued", cyc, n_issue, n_disp);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(negedge CLK) begin
        issue_stall = stall_rand ? ($urandom_range(2) == 0) : stall_force;
    end

    // FU model: accept each issue, write it back 1 to 6 cycles later
    always @(posedge CLK) begin
        if (nRST && issue_valid && !issue_stall) begin
            wbq_tag.push_back(issue_tag);
            wbq_data.push_back(fu_result(issue_op, issue_rdat1, issue_rdat2));
            wbq_due.push_back(cyc + 1 + $urandom_range(5));
        end
    end

    always @(negedge CLK) begin
        int k;
        k        = -1;
        wb_valid = 1'b0;
        for (int i = 0; i < wbq_tag.size(); i++) begin
            if (k < 0 && !fu_hold && wbq_due[i] <= cyc) k = i;
        end
        if (k >= 0) begin
            wb_valid = 1'b1;
            wb_tag   = wbq_tag[k];
            wb_data  = wbq_data[k];
            wbq_tag.delete(k);
            wbq_data.delete(k);
            wbq_due.delete(k);
        end
    end

    initial begin
        void'($urandom(32'h5577_16c8));
        nRST         = 1'b0;
        disp_valid   = 1'b0;
        disp_op      = issue_pkg::OP_ADD;
        disp_rd      = '0;
        disp_rs1     = '0;
        disp_rs2     = '0;
        issue_stall  = 1'b0;
        wb_valid     = 1'b0;
        wb_tag       = '0;
        wb_data      = '0;
        order_chk    = 1'b0;
        stall_rand   = 1'b0;
        stall_force  = 1'b0;
        fu_hold      = 1'b0;
        tb_errs      = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        @(negedge CLK);
        #1;
        if (issue_valid !== 1'b0) begin
            $display("MISMATCH t=%0t issue_valid expected 0 actual %b", $time, issue_valid);
            tb_errs++;
        end
        if (disp_ready !== 1'b1) begin
            $display("MISMATCH t=%0t disp_ready expected 1 actual %b", $time, disp_ready);
            tb_errs++;
        end
        end_test("reset state");

        stall_rand = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            send(issue_pkg::op_e'($urandom_range(4)), $urandom_range(7),
                 $urandom_range(7), $urandom_range(7));
        end
        stall_rand = 1'b0;
        drain();
        end_test("dependent program operands");

        fu_hold = 1'b1;
        send(issue_pkg::OP_ADD, 1, 2, 3);
        send(issue_pkg::OP_SUB, 4, 2, 5);
        @(negedge CLK);
        disp_op = issue_pkg::OP_XOR;
        disp_rd = 5'd6;
        for (int n = 0; n < 10; n++) begin
            #1;
            if (disp_ready) begin
                $display("ERROR t=%0t ALU credit still available after two ALU dispatches", $time);
                tb_errs++;
            end
            @(negedge CLK);
        end
        fu_hold = 1'b0;
        send(issue_pkg::OP_XOR, 6, 1, 4); // Waits for a returned credit
        send(issue_pkg::OP_ADD, 7, 6, 1);
        drain();
        end_test("ALU credits");

        stall_force = 1'b1;
        send(issue_pkg::OP_ADD, 11, 1, 2);
        send(issue_pkg::OP_MUL, 12, 3, 4);
        send(issue_pkg::OP_LD, 13, 5, 6);
        send(issue_pkg::OP_SUB, 14, 7, 1);
        send(issue_pkg::OP_MUL, 15, 2, 2);
        stall_force = 1'b0; // Stall drops at the next falling edge
        @(negedge CLK);
        disp_valid = 1'b0;
        order_chk  = 1'b1;
        t0         = cyc;
        while (n_issue < n_disp) @(negedge CLK);
        // Rows ready one edge later, then one issue per cycle
        if (cyc - t0 > 7) begin
            $display("ERROR t=%0t five ready instructions took %0d cycles to issue", $time,
                     cyc - t0);
            tb_errs++;
        end
        order_chk = 1'b0;
        drain();
        end_test("oldest first after stall");

        stall_rand = 1'b1;
        for (int n = 0; n < N_HOLD; n++) begin
            send(issue_pkg::op_e'($urandom_range(4)), 16 + $urandom_range(3),
                 16 + $urandom_range(3), $urandom_range(3));
        end
        stall_rand = 1'b0;
        drain();
        end_test("stall hold");

        if (n_issue != n_disp || n_disp != N_TOTAL) begin
            $display("ERROR %0d dispatched, %0d issued, %0d planned", n_disp, n_issue, N_TOTAL);
            tb_errs++;
        end
        end_test("completion");

        $display("tests %0d, failed %0d, errors %0d, dispatched %0d, issued %0d",
                 tests_run, tests_failed, chk_errors + tb_errs, n_disp, n_issue);
        if (chk_errors + tb_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
